//--- src/nnPkg.sv
`default_nettype none

package nnPkg;

	localparam int dataWidth = 16;

	// top two bits of the word address
	localparam logic [1:0] bankCtrl = 2'd0;
	localparam logic [1:0] bankAct = 2'd1;	// row must be 0, col is the input
	localparam logic [1:0] bankWeight = 2'd2;	// row is the neuron, col is the input
	localparam logic [1:0] bankBias = 2'd3;	// row is the neuron, col must be 0

	localparam logic [7:0] regCtrl = 8'h00;	// bit 0 written as 1 starts a layer run
	localparam logic [7:0] regStatus = 8'h01;	// bit 0 busy, bit 1 done
	localparam logic [7:0] regResultBase = 8'h10;	// result of neuron n at base plus n

	// word address, paddr bits 11 to 2
	typedef union packed {
		struct packed {
			logic [1:0] bank;
			logic [3:0] row;
			logic [3:0] col;
		} arrayView;
		struct packed {
			logic [1:0] bank;
			logic [7:0] regNum;
		} regView;
	} regAddr_t;

endpackage

`default_nettype wire

//--- src/apbRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module apbRegFile import nnPkg::*;
#(
	parameter int numInputs = 8,
	parameter int numNeurons = 4
)
(
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [11:0] paddr,
	input logic [dataWidth-1:0] pwdata,
	input logic [3:0] index,
	input logic busy,
	input logic done,
	input logic [numNeurons-1:0][dataWidth-1:0] results,
	output logic [dataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	output logic [dataWidth-1:0] curActivation,
	output logic [numNeurons-1:0][dataWidth-1:0] curWeights,
	output logic [numNeurons-1:0][dataWidth-1:0] biases
);
	localparam int inBits = (numInputs > 1) ? $clog2(numInputs) : 1;
	localparam int nBits = (numNeurons > 1) ? $clog2(numNeurons) : 1;

	regAddr_t addr;
	logic access;
	logic arrayBank;
	logic colOk;
	logic rowOk;
	logic [7:0] resNum;
	logic isResult;
	logic addrValid;
	logic wrEn;
	logic [dataWidth-1:0] readData;
	logic [dataWidth-1:0] activations [numInputs];
	logic [dataWidth-1:0] weights [numNeurons][numInputs];

	assign addr = paddr[11:2];
	assign access = psel && penable;
	assign arrayBank = addr.regView.bank != bankCtrl;
	assign colOk = {1'b0, addr.arrayView.col} < 5'(numInputs);
	assign rowOk = {1'b0, addr.arrayView.row} < 5'(numNeurons);
	assign resNum = addr.regView.regNum - regResultBase;
	assign isResult = (addr.regView.regNum >= regResultBase) && (resNum < 8'(numNeurons));

	always_comb
	begin
		case (addr.regView.bank)
			bankCtrl:
				addrValid = (addr.regView.regNum == regCtrl) ||
					(addr.regView.regNum == regStatus) || isResult;
			bankAct:
				addrValid = colOk && (addr.arrayView.row == 4'd0);
			bankWeight:
				addrValid = colOk && rowOk;
			default:
				addrValid = rowOk && (addr.arrayView.col == 4'd0);
		endcase
	end

	// operands must not change under a running layer, so array writes wait
	assign pready = !(access && pwrite && arrayBank && busy);
	assign pslverr = access && pready && !addrValid;
	assign wrEn = access && pwrite && pready && addrValid;

	always_comb
	begin
		readData = '0;
		case (addr.regView.bank)
			bankCtrl:
				if (addr.regView.regNum == regStatus)
					readData = {{(dataWidth-2){1'b0}}, done, busy};
				else if (isResult)
					readData = results[resNum[nBits-1:0]];	// regCtrl reads as zero
			bankAct:
				readData = activations[addr.arrayView.col[inBits-1:0]];
			bankWeight:
				readData = weights[addr.arrayView.row[nBits-1:0]][addr.arrayView.col[inBits-1:0]];
			default:
				readData = biases[addr.arrayView.row[nBits-1:0]];
		endcase
	end

	assign prdata = (access && !pwrite && addrValid) ? readData : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			start <= 1'b0;
			for (int i = 0; i < numInputs; i++)
				activations[i] <= '0;
			for (int n = 0; n < numNeurons; n++)
			begin
				biases[n] <= '0;
				for (int i = 0; i < numInputs; i++)
					weights[n][i] <= '0;
			end
		end
		else
		begin
			start <= wrEn && (addr.regView.bank == bankCtrl) &&
				(addr.regView.regNum == regCtrl) && pwdata[0];
			if (wrEn)
			begin
				case (addr.regView.bank)
					bankAct:
						activations[addr.arrayView.col[inBits-1:0]] <= pwdata;
					bankWeight:
						weights[addr.arrayView.row[nBits-1:0]][addr.arrayView.col[inBits-1:0]] <= pwdata;
					bankBias:
						biases[addr.arrayView.row[nBits-1:0]] <= pwdata;
					default:
						;	// status and result registers are read only
				endcase
			end
		end
	end

	// one input column broadcast to every neuron
	assign curActivation = activations[index[inBits-1:0]];

	always_comb
	begin
		for (int n = 0; n < numNeurons; n++)
			curWeights[n] = weights[n][index[inBits-1:0]];
	end

endmodule

`default_nettype wire

//--- src/layerSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module layerSequencer
#(
	parameter int numInputs = 8
)
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic [3:0] index,
	output logic clear,
	output logic accumulate,
	output logic finish,
	output logic busy,
	output logic done
);
	logic stepping;
	logic lastStep;
	logic lastAcc;
	logic accept;

	assign accept = start && !busy;	// a start during a run is dropped
	assign lastStep = stepping && (index == 4'(numInputs - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			index <= '0;
			stepping <= 1'b0;
			clear <= 1'b0;
			accumulate <= 1'b0;
			lastAcc <= 1'b0;
			finish <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			clear <= accept;
			accumulate <= stepping;	// neuron operands lag the index by one cycle
			lastAcc <= lastStep;
			finish <= lastAcc;

			if (accept)
			begin
				index <= '0;
				stepping <= 1'b1;
				busy <= 1'b1;
				done <= 1'b0;
			end
			else if (lastStep)
				stepping <= 1'b0;
			else if (stepping)
				index <= index + 4'd1;

			if (finish)
			begin
				busy <= 1'b0;
				done <= 1'b1;	// sticky until the next accepted start
			end
		end
	end

endmodule

`default_nettype wire

//--- src/neuronMac.sv
`timescale 1ns/1ps
`default_nettype none

module neuronMac import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic clear,
	input logic accumulate,
	input logic finish,
	input logic signed [dataWidth-1:0] activation,
	input logic signed [dataWidth-1:0] weight,
	input logic signed [dataWidth-1:0] bias,
	output logic [dataWidth-1:0] result
);
	logic signed [dataWidth-1:0] actReg;
	logic signed [dataWidth-1:0] weightReg;
	logic signed [dataWidth-1:0] product;
	logic signed [dataWidth-1:0] acc;
	logic signed [dataWidth-1:0] biased;

	assign product = actReg * weightReg;	// only the low half of the product survives
	assign biased = acc + bias;

	always_ff @(posedge clk)
	begin
		actReg <= activation;
		weightReg <= weight;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			result <= '0;
		end
		else
		begin
			if (clear)
				acc <= '0;
			else if (accumulate)
				acc <= acc + product;	// wraps in 16 bits, no saturation

			// ReLU
			if (finish)
				result <= biased[dataWidth-1] ? '0 : biased;
		end
	end

endmodule

`default_nettype wire

//--- src/nnLayerTop.sv
`timescale 1ns/1ps
`default_nettype none

module nnLayerTop import nnPkg::*;
#(
	parameter int numInputs = 8,
	parameter int numNeurons = 4
)
(
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [11:0] paddr,
	input logic [dataWidth-1:0] pwdata,
	output logic [dataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	logic start;
	logic [3:0] index;
	logic clear;
	logic accumulate;
	logic finish;
	logic busy;
	logic done;
	logic [dataWidth-1:0] curActivation;
	logic [numNeurons-1:0][dataWidth-1:0] curWeights;
	logic [numNeurons-1:0][dataWidth-1:0] biases;
	logic [numNeurons-1:0][dataWidth-1:0] results;

	apbRegFile #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) regFile (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.index(index),
		.busy(busy),
		.done(done),
		.results(results),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.start(start),
		.curActivation(curActivation),
		.curWeights(curWeights),
		.biases(biases)
	);

	layerSequencer #(
		.numInputs(numInputs)
	) sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.index(index),
		.clear(clear),
		.accumulate(accumulate),
		.finish(finish),
		.busy(busy),
		.done(done)
	);

	for (genvar n = 0; n < numNeurons; n++)
	begin : neuron
		neuronMac mac (
			.clk(clk),
			.reset(reset),
			.clear(clear),
			.accumulate(accumulate),
			.finish(finish),
			.activation(curActivation),
			.weight(curWeights[n]),
			.bias(biases[n]),
			.result(results[n])
		);
	end

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
	output logic clk,
	output logic reset
);
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (5) @(posedge clk);	// five rising edges under reset
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/nnLayerApb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module nnLayerApb_sva
(
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	input logic finish,
	input logic pready
);
	// the slave only inserts wait states while a layer is running
	readyWhenIdle: assert property (@(posedge clk) disable iff (reset) !busy |-> pready)
		else $error("pready low while the layer is idle");

	busyOrDone: assert property (@(posedge clk) disable iff (reset) !(busy && done))
		else $error("busy and done are high together");

	finishBeforeIdle: assert property (@(posedge clk) disable iff (reset) finish |=> $fell(busy))
		else $error("busy did not fall one cycle after finish");

endmodule

`default_nettype wire

//--- tests/nnLayerTb.sv
`timescale 1ns/1ps
`default_nettype none

module nnLayerTb import nnPkg::*; ();
	localparam int numInputs = 8;
	localparam int numNeurons = 4;
	localparam int opWrites = numInputs + numNeurons * numInputs + numNeurons;

	localparam logic [2:0] kindWrite = 3'd0;
	localparam logic [2:0] kindRead = 3'd1;
	localparam logic [2:0] kindRunFixed = 3'd2;
	localparam logic [2:0] kindRunRandom = 3'd3;
	localparam logic [2:0] kindBackPressure = 3'd4;

	typedef struct packed {
		logic [2:0] kind;
		logic [11:0] addr;
		logic [15:0] value;	// operand set number for fixed runs
		logic [15:0] expData;
		logic expErr;
	} row_t;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	logic [15:0] pwdata;
	logic [15:0] prdata;
	logic pready;
	logic pslverr;

	row_t stimRows [$];
	logic [15:0] act [numInputs];
	logic [15:0] wgt [numNeurons][numInputs];
	logic [15:0] bias [numNeurons];
	logic [15:0] lfsrState = 16'd68;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycleLimit = 0;

	clockGen clocks (.clk(clk), .reset(reset));

	nnLayerTop #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) DUT (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	bind nnLayerTop nnLayerApb_sva apbChecks (
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.done(done),
		.finish(finish),
		.pready(pready)
	);

	always @(posedge clk)
	begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit)
		begin
			$display("timeout: tests still running after %0d cycles", cycleLimit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] randomWord();
		logic [15:0] word;
		word = '0;
		for (int b = 0; b < 16; b++)
		begin
			lfsrState = lfsrStep(lfsrState);
			word = {word[14:0], lfsrState[0]};
		end
		return word;
	endfunction

	function automatic logic [11:0] arrayAddr(input logic [1:0] bank, input int row, input int col);
		return {bank, 4'(row), 4'(col), 2'b00};
	endfunction

	function automatic logic [11:0] ctrlAddr(input logic [7:0] regNum);
		return {bankCtrl, regNum, 2'b00};
	endfunction

	// full signed product, low half kept, wrapping sum, bias, then ReLU
	function automatic logic [15:0] neuronModel(input int n);
		logic [15:0] sum;
		int full;
		sum = '0;
		for (int i = 0; i < numInputs; i++)
		begin
			full = int'(signed'(act[i])) * int'(signed'(wgt[n][i]));
			sum = sum + full[15:0];
		end
		sum = sum + bias[n];
		return sum[15] ? 16'h0000 : sum;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("** Error: %s is %h, expected %h", name, got, expected);
		end
	endtask

	task automatic apbWrite(input logic [11:0] a, input logic [15:0] d, output logic err,
		output int stalls);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = a;
		pwdata = d;
		@(negedge clk);
		penable = 1'b1;
		stalls = 0;
		@(posedge clk);
		while (!pready)
		begin
			stalls++;
			@(posedge clk);
		end
		err = pslverr;
	endtask

	task automatic apbRead(input logic [11:0] a, output logic [15:0] data, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = a;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		while (!pready)
			@(posedge clk);
		data = prdata;
		err = pslverr;
	endtask

	task automatic busIdle();
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic writeNoError(input logic [11:0] a, input logic [15:0] d);
		logic err;
		int stalls;
		apbWrite(a, d, err, stalls);
		checkValue($sformatf("pslverr @%h", a), {15'd0, err}, 16'd0);
	endtask

	task automatic addRow(input logic [2:0] kind, input logic [11:0] addr,
		input logic [15:0] value, input logic [15:0] expData, input logic expErr);
		row_t r;
		r.kind = kind;
		r.addr = addr;
		r.value = value;
		r.expData = expData;
		r.expErr = expErr;
		stimRows.push_back(r);
	endtask

	task automatic buildTable();
		addRow(kindRead, ctrlAddr(regStatus), 16'h0, 16'h0000, 1'b0);
		for (int n = 0; n < numNeurons; n++)
			addRow(kindRead, ctrlAddr(regResultBase + 8'(n)), 16'h0, 16'h0000, 1'b0);
		addRow(kindWrite, arrayAddr(bankAct, 0, 2), 16'h1234, 16'h0, 1'b0);
		addRow(kindRead, arrayAddr(bankAct, 0, 2), 16'h0, 16'h1234, 1'b0);
		addRow(kindWrite, arrayAddr(bankWeight, 3, 7), 16'hbeef, 16'h0, 1'b0);
		addRow(kindRead, arrayAddr(bankWeight, 3, 7), 16'h0, 16'hbeef, 1'b0);
		addRow(kindWrite, arrayAddr(bankBias, 1, 0), 16'h8001, 16'h0, 1'b0);
		addRow(kindRead, arrayAddr(bankBias, 1, 0), 16'h0, 16'h8001, 1'b0);
		addRow(kindWrite, arrayAddr(bankAct, 0, 8), 16'h5555, 16'h0, 1'b1);	// index 8
		addRow(kindRead, arrayAddr(bankAct, 0, 8), 16'h0, 16'h0000, 1'b1);
		addRow(kindWrite, arrayAddr(bankWeight, 4, 0), 16'h7777, 16'h0, 1'b1);	// neuron 4
		addRow(kindRead, arrayAddr(bankWeight, 4, 0), 16'h0, 16'h0000, 1'b1);
		addRow(kindRead, arrayAddr(bankWeight, 0, 0), 16'h0, 16'h0000, 1'b0);
		addRow(kindRead, ctrlAddr(8'h05), 16'h0, 16'h0000, 1'b1);	// no such register
		addRow(kindRead, arrayAddr(bankAct, 0, 0), 16'h0, 16'h0000, 1'b0);	// index 8 aliases 0
		addRow(kindRunFixed, 12'h0, 16'd0, 16'h0, 1'b0);	// small values, negative weights
		addRow(kindRunFixed, 12'h0, 16'd1, 16'h0, 1'b0);	// products and sums overflow
		for (int k = 0; k < 3; k++)
			addRow(kindRunRandom, 12'h0, 16'h0, 16'h0, 1'b0);
		addRow(kindBackPressure, 12'h0, 16'h0, 16'h0, 1'b0);
	endtask

	task automatic fillOperands(input logic [2:0] kind, input logic [15:0] set);
		for (int i = 0; i < numInputs; i++)
		begin
			if (kind != kindRunFixed)
				act[i] = randomWord();
			else if (set == 16'd0)
				act[i] = 16'(i + 1);
			else
				act[i] = 16'h3f00 + 16'(i * 'h321);
		end
		for (int n = 0; n < numNeurons; n++)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				if (kind != kindRunFixed)
					wgt[n][i] = randomWord();
				else if (set == 16'd0)
					wgt[n][i] = 16'(2 * n + 1 - i);
				else
					wgt[n][i] = 16'h6100 - 16'(n * 'h2345) + 16'(i * 7);
			end
		end
		for (int n = 0; n < numNeurons; n++)
		begin
			if (kind != kindRunFixed)
				bias[n] = randomWord();
			else if (set == 16'd0)
				bias[n] = 16'(8 * n);
			else
				bias[n] = 16'(n * 'h3000);
		end
	endtask

	task automatic runLayer(input row_t r);
		logic [15:0] expected [numNeurons];
		logic [15:0] data;
		logic err;
		int stalls;
		fillOperands(r.kind, r.value);
		for (int i = 0; i < numInputs; i++)
			writeNoError(arrayAddr(bankAct, 0, i), act[i]);
		for (int n = 0; n < numNeurons; n++)
			for (int i = 0; i < numInputs; i++)
				writeNoError(arrayAddr(bankWeight, n, i), wgt[n][i]);
		for (int n = 0; n < numNeurons; n++)
			writeNoError(arrayAddr(bankBias, n, 0), bias[n]);
		for (int n = 0; n < numNeurons; n++)
			expected[n] = neuronModel(n);
		writeNoError(ctrlAddr(regCtrl), 16'h0001);
		if (r.kind == kindBackPressure)
		begin
			apbWrite(arrayAddr(bankWeight, 1, 3), ~wgt[1][3], err, stalls);
			if (stalls == 0)
			begin
				errors++;
				$display("weight write during a layer run completed without a wait state");
			end
			wgt[1][3] = ~wgt[1][3];
		end
		data = '0;
		while (!data[1])
			apbRead(ctrlAddr(regStatus), data, err);
		checkValue("status", data, 16'h0002);
		for (int n = 0; n < numNeurons; n++)
		begin
			apbRead(ctrlAddr(regResultBase + 8'(n)), data, err);
			checkValue($sformatf("result[%0d]", n), data, expected[n]);
		end
		if (r.kind == kindBackPressure)
		begin
			apbRead(arrayAddr(bankWeight, 1, 3), data, err);
			checkValue("weight[1][3]", data, wgt[1][3]);
		end
	endtask

	task automatic applyAccess(input row_t r);
		logic [15:0] data;
		logic err;
		int stalls;
		if (r.kind == kindWrite)
			apbWrite(r.addr, r.value, err, stalls);
		else
		begin
			apbRead(r.addr, data, err);
			checkValue($sformatf("prdata @%h", r.addr), data, r.expData);
		end
		checkValue($sformatf("pslverr @%h", r.addr), {15'd0, err}, {15'd0, r.expErr});
	endtask

	initial
	begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		buildTable();
		cycleLimit = stimRows.size() * (opWrites * 3 + numInputs + 20) + 100;
		wait (reset === 1'b0);
		foreach (stimRows[k])
		begin
			if (stimRows[k].kind == kindWrite || stimRows[k].kind == kindRead)
				applyAccess(stimRows[k]);
			else
				runLayer(stimRows[k]);
			busIdle();
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
src/nnPkg.sv
src/apbRegFile.sv
src/layerSequencer.sv
src/neuronMac.sv
src/nnLayerTop.sv
tests/clockGen.sv
tests/nnLayerApb_sva.sv
tests/nnLayerTb.sv

//--- Makefile
SRCS := $(shell cat build.f)

obj_dir/VnnLayerTb: build.f $(SRCS)
	verilator --binary --timing --assert --top-module nnLayerTb -f build.f

run: obj_dir/VnnLayerTb
	obj_dir/VnnLayerTb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
